// File: src/bpu_settings.svh
`ifndef BPU_SETTINGS_SVH
`define BPU_SETTINGS_SVH

// address and instruction width
`define BPU_XLEN 32

// global history length
`define BPU_HIST_WIDTH 16

// bimodal table indexed by pc[9:1]
`define BPU_BIMODAL_ENTRIES 512

// direct-mapped btb indexed by pc[7:2]
`define BPU_BTB_ENTRIES 64

// tag taken from the top pc bits
`define BPU_BTB_TAG_WIDTH 14

// return address stack entries
`define BPU_RAS_DEPTH 8

`endif

// File: src/bpu_pkg.sv
`include "bpu_settings.svh"

package bpu_pkg;

    typedef logic [`BPU_XLEN-1:0] addr_t;
    typedef logic [`BPU_XLEN-1:0] inst_t;
    typedef logic [`BPU_HIST_WIDTH-1:0] hist_t;
    typedef logic [1:0] ctr_t;
    typedef logic [`BPU_BTB_TAG_WIDTH-1:0] btb_tag_t;
    // occupancy count one bit wider than a stack index
    typedef logic [$clog2(`BPU_RAS_DEPTH):0] ras_ptr_t;

    typedef enum logic [2:0] {
        CLS_NONE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_RET
    } insn_class_t;

    function automatic insn_class_t classify(inst_t inst);
        insn_class_t cls;
        cls = CLS_NONE;
        if (inst[6:0] == 7'b1100011) begin
            cls = CLS_BRANCH;
        end else if (inst[6:0] == 7'b1101111) begin
            cls = CLS_JAL;
        end else if (inst[6:0] == 7'b1100111) begin
            // jalr x0, 0(ra) is the return idiom
            if (inst[11:7] == 5'd0 && inst[19:15] == 5'd1) begin
                cls = CLS_RET;
            end else begin
                cls = CLS_JALR;
            end
        end
        return cls;
    endfunction

    function automatic logic is_call(inst_t inst);
        insn_class_t cls;
        cls = classify(inst);
        return (cls == CLS_JAL) || (cls == CLS_JALR && inst[11:7] != 5'd0);
    endfunction

    function automatic addr_t branch_offset(inst_t inst);
        return {{(`BPU_XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic addr_t jal_offset(inst_t inst);
        return {{(`BPU_XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

endpackage

// File: src/bpu_ifc.sv
// resolved feedback from execute into the clocked structures
interface resolve_if (
    input logic clk,
    input logic rst
);
    logic                  commit;
    logic                  flush;
    logic                  taken;
    bpu_pkg::addr_t        pc;
    bpu_pkg::addr_t        target;
    bpu_pkg::insn_class_t  cls;
    logic                  call;
    bpu_pkg::hist_t        hist;

    modport drv (output commit, flush, taken, pc, target, cls, call, hist);
    modport sink (input clk, rst, commit, flush, taken, pc, target, cls, call, hist);
endinterface

// fetch-side lookup with answers combinational from pc
interface lookup_if;
    bpu_pkg::addr_t pc;
    logic           btb_hit;
    bpu_pkg::addr_t btb_target;
    logic           ctr_taken;
    logic           ras_valid;
    bpu_pkg::addr_t ras_top;

    modport req (output pc, input btb_hit, btb_target, ctr_taken, ras_valid, ras_top);
    modport btb (input pc, output btb_hit, btb_target);
    modport dir (input pc, output ctr_taken);
    modport ras (output ras_valid, ras_top);
endinterface

// File: src/resolve_decode.sv
module resolve_decode (
    input  logic           if_stall_i,
    input  logic           flush_i,
    input  logic           ex_valid_i,
    input  logic           ex_stall_i,
    input  logic           ex_taken_i,
    input  bpu_pkg::addr_t ex_pc_i,
    input  bpu_pkg::addr_t ex_target_i,
    input  bpu_pkg::inst_t ex_inst_i,
    input  bpu_pkg::hist_t ex_history_i,
    resolve_if.drv         res_o
);

    // any stall or a flush holds back the update
    assign res_o.commit = ex_valid_i && !if_stall_i && !ex_stall_i && !flush_i;

    // flush only restores the history
    assign res_o.flush = flush_i;
    assign res_o.hist  = ex_history_i;

    assign res_o.taken  = ex_taken_i;
    assign res_o.pc     = ex_pc_i;
    assign res_o.target = ex_target_i;

    // class of the resolved instruction
    assign res_o.cls  = bpu_pkg::classify(ex_inst_i);
    assign res_o.call = bpu_pkg::is_call(ex_inst_i);

endmodule

// File: src/target_buffer.sv
`include "bpu_settings.svh"

module target_buffer (
    resolve_if.sink res_i,
    lookup_if.btb   look_io
);

    localparam int IDX_W = $clog2(`BPU_BTB_ENTRIES);

    logic [`BPU_BTB_ENTRIES-1:0] valid_q;
    bpu_pkg::btb_tag_t           tag_mem    [`BPU_BTB_ENTRIES];
    bpu_pkg::addr_t              target_mem [`BPU_BTB_ENTRIES];

    logic [IDX_W-1:0]  wr_idx;
    logic [IDX_W-1:0]  rd_idx;
    bpu_pkg::btb_tag_t wr_tag;
    bpu_pkg::btb_tag_t rd_tag;
    logic              wr_en;

    // word index and a tag from the top bits
    assign rd_idx = look_io.pc[IDX_W+1:2];
    assign rd_tag = look_io.pc[`BPU_XLEN-1 -: `BPU_BTB_TAG_WIDTH];
    assign wr_idx = res_i.pc[IDX_W+1:2];
    assign wr_tag = res_i.pc[`BPU_XLEN-1 -: `BPU_BTB_TAG_WIDTH];

    // only taken control transfers allocate
    assign wr_en = res_i.commit && res_i.taken && (res_i.cls != bpu_pkg::CLS_NONE);

    always_ff @(posedge res_i.clk) begin
        if (res_i.rst) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge res_i.clk) begin
        if (wr_en) begin
            tag_mem[wr_idx]    <= wr_tag;
            target_mem[wr_idx] <= res_i.target;
        end
    end

    assign look_io.btb_hit    = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign look_io.btb_target = target_mem[rd_idx];

endmodule

// File: src/direction_predictor.sv
`include "bpu_settings.svh"

module direction_predictor (
    resolve_if.sink        res_i,
    lookup_if.dir          look_io,
    output bpu_pkg::hist_t history_o
);

    localparam int IDX_W = $clog2(`BPU_BIMODAL_ENTRIES);

    bpu_pkg::ctr_t  ctr_q [`BPU_BIMODAL_ENTRIES];
    bpu_pkg::hist_t hist_q;

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             br_commit;
    bpu_pkg::ctr_t    ctr_cur;
    bpu_pkg::ctr_t    ctr_next;

    // halfword index so compressed code spreads too
    assign rd_idx = look_io.pc[IDX_W:1];
    assign wr_idx = res_i.pc[IDX_W:1];

    assign br_commit = res_i.commit && (res_i.cls == bpu_pkg::CLS_BRANCH);

    // saturating step toward the outcome
    assign ctr_cur = ctr_q[wr_idx];
    always_comb begin
        ctr_next = ctr_cur;
        if (res_i.taken && ctr_cur != 2'b11) begin
            ctr_next = ctr_cur + 2'b01;
        end else if (!res_i.taken && ctr_cur != 2'b00) begin
            ctr_next = ctr_cur - 2'b01;
        end
    end

    always_ff @(posedge res_i.clk) begin
        if (res_i.rst) begin
            // weakly not taken
            for (int i = 0; i < `BPU_BIMODAL_ENTRIES; i++) begin
                ctr_q[i] <= 2'b01;
            end
        end else if (br_commit) begin
            ctr_q[wr_idx] <= ctr_next;
        end
    end

    // flush restore wins over a shift
    always_ff @(posedge res_i.clk) begin
        if (res_i.rst) begin
            hist_q <= '0;
        end else if (res_i.flush) begin
            hist_q <= res_i.hist;
        end else if (br_commit) begin
            hist_q <= {hist_q[`BPU_HIST_WIDTH-2:0], res_i.taken};
        end
    end

    assign look_io.ctr_taken = ctr_q[rd_idx][1];
    assign history_o         = hist_q;

endmodule

// File: src/return_stack.sv
`include "bpu_settings.svh"

module return_stack (
    resolve_if.sink res_i,
    lookup_if.ras   look_io
);

    localparam int IDX_W = $clog2(`BPU_RAS_DEPTH);
    localparam bpu_pkg::ras_ptr_t RAS_FULL = bpu_pkg::ras_ptr_t'(`BPU_RAS_DEPTH);

    bpu_pkg::addr_t    stack_mem [`BPU_RAS_DEPTH];
    bpu_pkg::ras_ptr_t count_q;
    bpu_pkg::ras_ptr_t top_ptr;

    logic             push;
    logic             pop;
    logic             full;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    assign push = res_i.commit && res_i.call;
    // return on an empty stack is ignored
    assign pop  = res_i.commit && (res_i.cls == bpu_pkg::CLS_RET) && (count_q != '0);
    assign full = (count_q == RAS_FULL);

    // a full count has zero low bits and so wraps to entry 0
    assign wr_idx = count_q[IDX_W-1:0];

    always_ff @(posedge res_i.clk) begin
        if (res_i.rst) begin
            count_q <= '0;
        end else if (push) begin
            count_q <= full ? bpu_pkg::ras_ptr_t'(1) : count_q + 1'b1;
        end else if (pop) begin
            count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge res_i.clk) begin
        if (push) begin
            stack_mem[wr_idx] <= res_i.pc + bpu_pkg::addr_t'(4);
        end
    end

    // top of stack sits at count - 1
    assign top_ptr = count_q - 1'b1;
    assign rd_idx  = top_ptr[IDX_W-1:0];

    assign look_io.ras_valid = (count_q != '0);
    assign look_io.ras_top   = stack_mem[rd_idx];

endmodule

// File: src/predict_select.sv
module predict_select (
    input  bpu_pkg::addr_t fetch_pc_i,
    input  bpu_pkg::inst_t fetch_inst_i,
    input  logic           flush_i,
    lookup_if.req          look_io,
    output logic           pred_ctrl_o,
    output logic           pred_taken_o,
    output bpu_pkg::addr_t pred_pc_o
);

    bpu_pkg::insn_class_t cls;
    bpu_pkg::addr_t       seq_pc;
    bpu_pkg::addr_t       jal_pc;
    bpu_pkg::addr_t       br_pc;
    bpu_pkg::addr_t       taken_pc;
    logic                 taken;

    assign look_io.pc = fetch_pc_i;

    assign cls    = bpu_pkg::classify(fetch_inst_i);
    assign seq_pc = fetch_pc_i + bpu_pkg::addr_t'(4);
    assign jal_pc = fetch_pc_i + bpu_pkg::jal_offset(fetch_inst_i);
    assign br_pc  = fetch_pc_i + bpu_pkg::branch_offset(fetch_inst_i);

    always_comb begin
        taken    = 1'b0;
        taken_pc = seq_pc;
        case (cls)
            bpu_pkg::CLS_RET: begin
                // stack first with the btb as fallback
                if (look_io.ras_valid) begin
                    taken    = 1'b1;
                    taken_pc = look_io.ras_top;
                end else if (look_io.btb_hit) begin
                    taken    = 1'b1;
                    taken_pc = look_io.btb_target;
                end
            end
            bpu_pkg::CLS_JALR: begin
                taken    = look_io.btb_hit;
                taken_pc = look_io.btb_target;
            end
            bpu_pkg::CLS_JAL: begin
                taken    = 1'b1;
                taken_pc = jal_pc;
            end
            bpu_pkg::CLS_BRANCH: begin
                taken    = look_io.ctr_taken;
                taken_pc = look_io.btb_hit ? look_io.btb_target : br_pc;
            end
            default: begin
                taken    = 1'b0;
                taken_pc = seq_pc;
            end
        endcase
    end

    // a flushed fetch falls through
    assign pred_ctrl_o  = !flush_i && (cls != bpu_pkg::CLS_NONE);
    assign pred_taken_o = !flush_i && taken;
    assign pred_pc_o    = (flush_i || !taken) ? seq_pc : taken_pc;

endmodule

// File: src/bpu_top.sv
module bpu_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           if_stall_i,
    input  logic           flush_i,
    input  bpu_pkg::addr_t fetch_pc_i,
    input  bpu_pkg::inst_t fetch_inst_i,
    input  logic           ex_valid_i,
    input  logic           ex_taken_i,
    input  bpu_pkg::addr_t ex_pc_i,
    input  bpu_pkg::addr_t ex_target_i,
    input  bpu_pkg::inst_t ex_inst_i,
    input  bpu_pkg::hist_t ex_history_i,
    input  logic           ex_stall_i,
    output logic           pred_ctrl_o,
    output logic           pred_taken_o,
    output bpu_pkg::addr_t pred_pc_o,
    output bpu_pkg::hist_t history_o
);

    resolve_if res_bus (.clk(clk), .rst(rst));
    lookup_if  look_bus ();

    // execute feedback
    resolve_decode u_decode (
        .if_stall_i   (if_stall_i),
        .flush_i      (flush_i),
        .ex_valid_i   (ex_valid_i),
        .ex_stall_i   (ex_stall_i),
        .ex_taken_i   (ex_taken_i),
        .ex_pc_i      (ex_pc_i),
        .ex_target_i  (ex_target_i),
        .ex_inst_i    (ex_inst_i),
        .ex_history_i (ex_history_i),
        .res_o        (res_bus.drv)
    );

    target_buffer u_btb (
        .res_i   (res_bus.sink),
        .look_io (look_bus.btb)
    );

    direction_predictor u_dir (
        .res_i     (res_bus.sink),
        .look_io   (look_bus.dir),
        .history_o (history_o)
    );

    return_stack u_ras (
        .res_i   (res_bus.sink),
        .look_io (look_bus.ras)
    );

    // fetch-side prediction
    predict_select u_select (
        .fetch_pc_i   (fetch_pc_i),
        .fetch_inst_i (fetch_inst_i),
        .flush_i      (flush_i),
        .look_io      (look_bus.req),
        .pred_ctrl_o  (pred_ctrl_o),
        .pred_taken_o (pred_taken_o),
        .pred_pc_o    (pred_pc_o)
    );

endmodule

// File: test/bpu_properties.sv
module bpu_properties (
    input logic           clk,
    input logic           rst,
    input logic           flush_i,
    input logic           stall_i,
    input logic           ctrl_i,
    input logic           taken_i,
    input bpu_pkg::hist_t ex_hist_i,
    input bpu_pkg::hist_t hist_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int flush_fails = 0;
    int stall_fails = 0;
    int ctrl_fails  = 0;

    // flush restores the history from execute
    restore_on_flush: assert property (@(posedge clk) disable iff (rst)
        flush_i |=> hist_i == $past(ex_hist_i))
        else begin
            $error("history_o did not load ex_history_i after a flush");
            flush_fails++;
        end

    hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        stall_i && !flush_i |=> $stable(hist_i))
        else begin
            $error("history_o changed while if_stall_i was high");
            stall_fails++;
        end

    // a taken prediction is always a control transfer
    taken_is_ctrl: assert property (@(posedge clk) disable iff (rst)
        taken_i |-> ctrl_i)
        else begin
            $error("pred_taken_o high without pred_ctrl_o");
            ctrl_fails++;
        end

endmodule

bind bpu_top bpu_properties u_props (
    .clk       (clk),
    .rst       (rst),
    .flush_i   (flush_i),
    .stall_i   (if_stall_i),
    .ctrl_i    (pred_ctrl_o),
    .taken_i   (pred_taken_o),
    .ex_hist_i (ex_history_i),
    .hist_i    (history_o)
);

// File: test/bpu_checker.sv
`include "bpu_settings.svh"

module bpu_checker (
    input  logic           clk,
    input  logic           rst,
    input  logic           if_stall_i,
    input  logic           flush_i,
    input  logic           ex_valid_i,
    input  logic           ex_stall_i,
    input  logic           ex_taken_i,
    input  bpu_pkg::addr_t fetch_pc_i,
    input  bpu_pkg::inst_t fetch_inst_i,
    input  bpu_pkg::addr_t ex_pc_i,
    input  bpu_pkg::addr_t ex_target_i,
    input  bpu_pkg::inst_t ex_inst_i,
    input  bpu_pkg::hist_t ex_history_i,
    input  logic           pred_ctrl_i,
    input  logic           pred_taken_i,
    input  bpu_pkg::addr_t pred_pc_i,
    input  bpu_pkg::hist_t history_i,
    input  logic           finish_i,
    output logic           done_o,
    output int             error_count_o,
    output int             check_count_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int K_NONE   = 0;
    localparam int K_BRANCH = 1;
    localparam int K_JAL    = 2;
    localparam int K_JALR   = 3;
    localparam int K_RET    = 4;
    localparam int RAS_W    = $clog2(`BPU_RAS_DEPTH);

    logic              btb_valid [`BPU_BTB_ENTRIES];
    bpu_pkg::btb_tag_t btb_tag   [`BPU_BTB_ENTRIES];
    bpu_pkg::addr_t    btb_tgt   [`BPU_BTB_ENTRIES];
    bpu_pkg::ctr_t     ctr_m     [`BPU_BIMODAL_ENTRIES];
    bpu_pkg::addr_t    ras_m     [`BPU_RAS_DEPTH];
    int                ras_cnt;
    bpu_pkg::hist_t    hist_m;

    function automatic int decode_kind(input logic [31:0] inst);
        int k;
        k = K_NONE;
        if (inst[6:0] == 7'h63) begin
            k = K_BRANCH;
        end else if (inst[6:0] == 7'h6f) begin
            k = K_JAL;
        end else if (inst[6:0] == 7'h67) begin
            k = (inst[11:7] == 5'd0 && inst[19:15] == 5'd1) ? K_RET : K_JALR;
        end
        return k;
    endfunction

    function automatic logic [31:0] b_immediate(input logic [31:0] inst);
        logic [12:0] imm;
        imm = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        return {{19{imm[12]}}, imm};
    endfunction

    function automatic logic [31:0] j_immediate(input logic [31:0] inst);
        logic [20:0] imm;
        imm = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        return {{11{imm[20]}}, imm};
    endfunction

    // reference state follows the resolved stream
    always @(posedge clk) begin : model_update
        int   k;
        logic commit;
        if (rst) begin
            for (int i = 0; i < `BPU_BIMODAL_ENTRIES; i++) ctr_m[i] = 2'b01;
            for (int i = 0; i < `BPU_BTB_ENTRIES; i++) btb_valid[i] = 1'b0;
            ras_cnt = 0;
            hist_m  = '0;
        end else begin
            k      = decode_kind(ex_inst_i);
            commit = ex_valid_i && !if_stall_i && !ex_stall_i && !flush_i;
            if (commit && ex_taken_i && k != K_NONE) begin
                btb_valid[ex_pc_i[7:2]] = 1'b1;
                btb_tag[ex_pc_i[7:2]]   = ex_pc_i[31:18];
                btb_tgt[ex_pc_i[7:2]]   = ex_target_i;
            end
            if (commit && k == K_BRANCH) begin
                if (ex_taken_i && ctr_m[ex_pc_i[9:1]] != 2'b11) begin
                    ctr_m[ex_pc_i[9:1]] = ctr_m[ex_pc_i[9:1]] + 2'b01;
                end else if (!ex_taken_i && ctr_m[ex_pc_i[9:1]] != 2'b00) begin
                    ctr_m[ex_pc_i[9:1]] = ctr_m[ex_pc_i[9:1]] - 2'b01;
                end
                hist_m = {hist_m[`BPU_HIST_WIDTH-2:0], ex_taken_i};
            end
            // calls push pc+4 and a full stack restarts at entry 0
            if (commit && (k == K_JAL || (k == K_JALR && ex_inst_i[11:7] != 5'd0))) begin
                if (ras_cnt == `BPU_RAS_DEPTH) begin
                    ras_m[0] = ex_pc_i + 32'd4;
                    ras_cnt  = 1;
                end else begin
                    ras_m[RAS_W'(ras_cnt)] = ex_pc_i + 32'd4;
                    ras_cnt++;
                end
            end else if (commit && k == K_RET && ras_cnt > 0) begin
                ras_cnt--;
            end
            if (flush_i) hist_m = ex_history_i;
        end
    end

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count_o++;
        if (got !== exp) begin
            error_count_o++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h (fetch pc 0x%08h, %0t)",
                     name, got, exp, fetch_pc_i, $time);
        end
    endtask

    task automatic compare_outputs();
        int             k;
        logic           hit;
        logic           exp_taken;
        bpu_pkg::addr_t seq_pc;
        bpu_pkg::addr_t exp_pc;
        k         = decode_kind(fetch_inst_i);
        seq_pc    = fetch_pc_i + 32'd4;
        hit       = btb_valid[fetch_pc_i[7:2]] && btb_tag[fetch_pc_i[7:2]] == fetch_pc_i[31:18];
        exp_taken = 1'b0;
        exp_pc    = seq_pc;
        if (k == K_RET && ras_cnt > 0) begin
            exp_taken = 1'b1;
            exp_pc    = ras_m[RAS_W'(ras_cnt - 1)];
        end else if ((k == K_RET || k == K_JALR) && hit) begin
            exp_taken = 1'b1;
            exp_pc    = btb_tgt[fetch_pc_i[7:2]];
        end else if (k == K_JAL) begin
            exp_taken = 1'b1;
            exp_pc    = fetch_pc_i + j_immediate(fetch_inst_i);
        end else if (k == K_BRANCH && ctr_m[fetch_pc_i[9:1]][1]) begin
            exp_taken = 1'b1;
            exp_pc    = hit ? btb_tgt[fetch_pc_i[7:2]] : fetch_pc_i + b_immediate(fetch_inst_i);
        end
        if (flush_i) begin
            exp_taken = 1'b0;
            exp_pc    = seq_pc;
        end
        check_field("pred_ctrl_o", 32'(pred_ctrl_i), 32'(!flush_i && k != K_NONE));
        check_field("pred_taken_o", 32'(pred_taken_i), 32'(exp_taken));
        check_field("pred_pc_o", pred_pc_i, exp_pc);
        check_field("history_o", 32'(history_i), 32'(hist_m));
    endtask

    // sample late in the cycle once the inputs have settled
    initial begin
        done_o        = 1'b0;
        error_count_o = 0;
        check_count_o = 0;
        forever begin
            @(posedge clk);
            #36;
            if (!rst) compare_outputs();
            if (finish_i) done_o = 1'b1;
        end
    end

endmodule

// File: test/bpu_tb.sv
module bpu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_CYCLES   = 4000;
    localparam int DONE_TIMEOUT = 10;

    logic           clk;
    logic           rst;
    logic           if_stall;
    logic           flush;
    logic           ex_valid;
    logic           ex_taken;
    logic           ex_stall;
    bpu_pkg::addr_t fetch_pc;
    bpu_pkg::inst_t fetch_inst;
    bpu_pkg::addr_t ex_pc;
    bpu_pkg::addr_t ex_target;
    bpu_pkg::inst_t ex_inst;
    bpu_pkg::hist_t ex_history;
    logic           pred_ctrl;
    logic           pred_taken;
    bpu_pkg::addr_t pred_pc;
    bpu_pkg::hist_t history;
    logic           run_done;
    logic           chk_done;
    int             chk_errors;
    int             chk_checks;
    int             assert_fails;
    int             wait_cycles;
    logic           timed_out;
    logic [31:0]    lfsr_state;

    always #20 clk = ~clk;

    bpu_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .if_stall_i   (if_stall),
        .flush_i      (flush),
        .fetch_pc_i   (fetch_pc),
        .fetch_inst_i (fetch_inst),
        .ex_valid_i   (ex_valid),
        .ex_taken_i   (ex_taken),
        .ex_pc_i      (ex_pc),
        .ex_target_i  (ex_target),
        .ex_inst_i    (ex_inst),
        .ex_history_i (ex_history),
        .ex_stall_i   (ex_stall),
        .pred_ctrl_o  (pred_ctrl),
        .pred_taken_o (pred_taken),
        .pred_pc_o    (pred_pc),
        .history_o    (history)
    );

    bpu_checker checker_i (
        .clk           (clk),
        .rst           (rst),
        .if_stall_i    (if_stall),
        .flush_i       (flush),
        .ex_valid_i    (ex_valid),
        .ex_stall_i    (ex_stall),
        .ex_taken_i    (ex_taken),
        .fetch_pc_i    (fetch_pc),
        .fetch_inst_i  (fetch_inst),
        .ex_pc_i       (ex_pc),
        .ex_target_i   (ex_target),
        .ex_inst_i     (ex_inst),
        .ex_history_i  (ex_history),
        .pred_ctrl_i   (pred_ctrl),
        .pred_taken_i  (pred_taken),
        .pred_pc_i     (pred_pc),
        .history_i     (history),
        .finish_i      (run_done),
        .done_o        (chk_done),
        .error_count_o (chk_errors),
        .check_count_o (chk_checks)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    // upper half of the pool aliases the lower half with another tag
    function automatic logic [31:0] pool_pc(input logic [3:0] idx);
        return 32'h0002_0100 + 32'(idx[2:0]) * 32'd12 + (idx[3] ? 32'h0040_0000 : 32'd0);
    endfunction

    function automatic logic [31:0] make_inst(input logic ret_bias);
        logic [2:0]  kind;
        logic [31:0] w;
        kind = 3'(take_bits(3));
        w    = take_bits(25) << 7;
        if (ret_bias && (kind == 3'd2 || kind == 3'd3)) kind = 3'd4;
        case (kind)
            3'd0, 3'd1: w[6:0] = 7'b1100011;
            3'd2:       w[6:0] = 7'b1101111;
            3'd3: begin
                // jalr ra as a call
                w[6:0]  = 7'b1100111;
                w[11:7] = 5'd1;
            end
            3'd4: begin
                w[6:0]   = 7'b1100111;
                w[11:7]  = 5'd0;
                w[19:15] = 5'd1;
            end
            3'd5: begin
                w[6:0]   = 7'b1100111;
                w[11:7]  = 5'd0;
                w[19:15] = 5'd6;
            end
            default: w[6:0] = 7'b0010011;
        endcase
        return w;
    endfunction

    task automatic drive_cycle(input logic ret_bias);
        logic [3:0] ex_idx;
        fetch_pc   = pool_pc(4'(take_bits(4)));
        fetch_inst = make_inst(1'b0);
        ex_idx     = 4'(take_bits(4));
        ex_pc      = pool_pc(ex_idx);
        ex_inst    = make_inst(ret_bias);
        ex_valid   = take_bits(2) != 0;
        // branches lean taken or not taken by pool slot
        if (ex_inst[6:0] == 7'b1100011) begin
            ex_taken = (take_bits(2) != 0) ^ ex_idx[2];
        end else begin
            ex_taken = (ex_inst[6:0] != 7'b0010011) || (take_bits(1) != 0);
        end
        ex_target  = take_bits(30) << 2;
        ex_history = 16'(take_bits(16));
        if_stall   = take_bits(4) == 0;
        ex_stall   = take_bits(4) == 0;
        flush      = take_bits(5) == 0;
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        if_stall   = 1'b0;
        flush      = 1'b0;
        ex_valid   = 1'b0;
        ex_taken   = 1'b0;
        ex_stall   = 1'b0;
        fetch_pc   = '0;
        fetch_inst = '0;
        ex_pc      = '0;
        ex_target  = '0;
        ex_inst    = '0;
        ex_history = '0;
        run_done   = 1'b0;
        timed_out  = 1'b0;
        lfsr_state = 32'h4f1f_a7f5;
        for (int i = 0; i < 3; i++) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int n = 0; n < NUM_CYCLES; n++) begin
            // a window of returns drains the stack and pops it empty
            drive_cycle(n >= 1500 && n < 2100);
            @(posedge clk);
            #2;
        end
        run_done    = 1'b1;
        wait_cycles = 0;
        while (!chk_done && wait_cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (!chk_done) begin
            $display("bpu_tb: checker did not finish within %0d cycles", DONE_TIMEOUT);
            timed_out = 1'b1;
        end
        assert_fails = dut_i.u_props.flush_fails + dut_i.u_props.stall_fails
                     + dut_i.u_props.ctrl_fails;
        $display("bpu_tb: %0d checks, %0d compare errors, %0d assertion failures",
                 chk_checks, chk_errors, assert_fails);
        if (chk_errors == 0 && assert_fails == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+src
src/bpu_pkg.sv
src/bpu_ifc.sv
src/resolve_decode.sv
src/target_buffer.sv
src/direction_predictor.sv
src/return_stack.sv
src/predict_select.sv
src/bpu_top.sv
test/bpu_properties.sv
test/bpu_checker.sv
test/bpu_tb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module bpu_tb -f all.f -o bpu_sim \
    && ./obj_dir/bpu_sim +verilator+error+limit+100 > sim.log 2>&1
grep -q "^TESTBENCH PASSED$" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
